//--- design/ymem_pkg.sv
// ==========================================================
// Y memory package
// Shared widths, the two-way entry decode and the channel
// structs used by the Y-value filter.
// ==========================================================
`default_nettype none

package ymem_pkg;

   localparam int idx_w            = 16;  // row and column index fields
   localparam int row_w            = 9;   // significant row bits, up to 512 buses
   localparam int part_w           = 24;  // real or imaginary part
   localparam int val_w            = 2 * part_w;
   localparam int entry_w          = 64;
   localparam int entries_per_line = 4;
   localparam int lines_per_fetch  = 2;
   localparam int block_entries    = entries_per_line * lines_per_fetch;

   localparam int marker_w = 3;
   localparam int spare_w  = entry_w - marker_w - row_w - val_w;

   localparam logic [marker_w-1:0] header_marker = 3'b111;

   typedef struct packed {
      logic [part_w-1:0] re;
      logic [part_w-1:0] im;
   } cplx_t;

   // off-diagonal entry
   typedef struct packed {
      logic [idx_w-1:0] col;
      cplx_t            value;
   } col_entry_t;

   // row header, marker bits on top
   typedef struct packed {
      logic [marker_w-1:0] marker;
      logic [spare_w-1:0]  spare;
      logic [row_w-1:0]    row;
      cplx_t               diag;
   } hdr_entry_t;

   // same 64 bits, read as header or column entry
   typedef union packed {
      col_entry_t col;
      hdr_entry_t hdr;
   } y_entry_u;

   // entry 0 is the top entry of line 0
   typedef y_entry_u [0:block_entries-1] y_block_t;

   typedef struct packed {
      logic [idx_w-1:0] row;
      logic [idx_w-1:0] col;
      cplx_t            value;
   } change_req_t;

   typedef struct packed {
      logic  hdr_found;
      cplx_t diag;
      logic  col_found;
      cplx_t offdiag;
   } scan_result_t;

   typedef struct packed {
      cplx_t yval1;
      cplx_t yval2;
      logic  found;
      logic  last;                        // final beat of a request
   } y_beat_t;

endpackage

`default_nettype wire

//--- design/row_fetch.sv
// ==========================================================
// Row fetch
// Issues one row read to Y memory, holds the request until
// the handshake completes, then captures the returned
// two-line block and pulses fetch_done.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module row_fetch (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        fetch_start,
   input  logic [ymem_pkg::idx_w-1:0]  fetch_row,
   output logic [ymem_pkg::idx_w-1:0]  rd_row,
   output logic                        rd_valid,
   input  logic                        rd_ready,
   input  ymem_pkg::y_block_t          rsp_block,
   input  logic                        rsp_valid,
   output logic                        fetch_done,
   output ymem_pkg::y_block_t          block
);

   logic waiting;                      // read accepted, response pending

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         rd_valid   <= 1'b0;
         waiting    <= 1'b0;
         fetch_done <= 1'b0;
      end
      else
      begin
         fetch_done <= 1'b0;           // single-cycle pulse
         if (fetch_start)
         begin
            rd_valid <= 1'b1;
         end
         else if (rd_valid && rd_ready)
         begin
            rd_valid <= 1'b0;
            waiting  <= 1'b1;
         end
         if (waiting && rsp_valid)
         begin
            waiting    <= 1'b0;
            fetch_done <= 1'b1;
         end
      end
   end

   // request address, held while rd_valid is up
   always_ff @(posedge clock)
   begin
      if (fetch_start)
      begin
         rd_row <= fetch_row;
      end
   end

   // block register stays put until the next response
   always_ff @(posedge clock)
   begin
      if (waiting && rsp_valid)
      begin
         block <= rsp_block;
      end
   end

endmodule

`default_nettype wire

//--- design/row_scanner.sv
// ==========================================================
// Row scanner
// Searches a fetched block for the row header among the
// first four entries, then for the requested column in the
// entries that follow the header. Purely combinational.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module row_scanner (
   input  ymem_pkg::y_block_t          block,
   input  logic [ymem_pkg::idx_w-1:0]  search_row,
   input  logic [ymem_pkg::idx_w-1:0]  search_col,
   output ymem_pkg::scan_result_t      result
);

   import ymem_pkg::*;

   y_entry_u                       ent;
   logic                           past_hdr;
   logic                           hdr_hit;
   logic                           col_hit;
   logic [block_entries-1:0]       is_hdr;
   logic [block_entries-1:0]       is_col;

   // per-entry match flags from both decodes
   always_comb
   begin
      for (int i = 0; i < block_entries; i++)
      begin
         ent = block[i];
         is_hdr[i] = (i < entries_per_line)
                     && (ent.hdr.marker == header_marker)
                     && (idx_w'(ent.hdr.row) == search_row);
         is_col[i] = (ent.col.col == search_col);
      end
   end

   // single positional pass, column checked before header
   // so the header slot itself is never taken as a column
   always_comb
   begin
      result   = '0;
      past_hdr = 1'b0;
      hdr_hit  = 1'b0;
      col_hit  = 1'b0;
      for (int i = 0; i < block_entries; i++)
      begin
         if (past_hdr && !col_hit && is_col[i])
         begin
            col_hit        = 1'b1;
            result.offdiag = block[i].col.value;
         end
         if (!past_hdr && is_hdr[i])
         begin
            past_hdr    = 1'b1;
            hdr_hit     = 1'b1;
            result.diag = block[i].hdr.diag;
         end
      end
      result.hdr_found = hdr_hit;
      result.col_found = col_hit;      // only set once a header is seen
   end

endmodule

`default_nettype wire

//--- design/change_sequencer.sv
// ==========================================================
// Change sequencer
// Accepts a change request and runs two passes, (row, col)
// then (col, row). Each pass fetches one row block and
// offers a diagonal beat and an off-diagonal beat on the
// output channel under back-pressure.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module change_sequencer (
   input  logic                        clock,
   input  logic                        reset,
   input  ymem_pkg::change_req_t       chng,
   input  logic                        chng_valid,
   output logic                        chng_ready,
   output logic                        fetch_start,
   output logic [ymem_pkg::idx_w-1:0]  fetch_row,
   output logic [ymem_pkg::idx_w-1:0]  search_row,
   output logic [ymem_pkg::idx_w-1:0]  search_col,
   input  logic                        fetch_done,
   input  ymem_pkg::scan_result_t      result,
   output ymem_pkg::y_beat_t           y_out,
   output logic                        y_out_valid,
   input  logic                        y_out_ready
);

   import ymem_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_fetch,
      st_diag,
      st_offd
   } state_t;

   state_t       state;
   logic         pass;                 // 0 for (row, col), 1 for (col, row)
   change_req_t  req;
   scan_result_t res;
   logic         accept;
   logic         beat_xfer;

   assign chng_ready  = (state == st_idle);
   assign accept      = chng_ready && chng_valid;
   assign y_out_valid = (state == st_diag) || (state == st_offd);
   assign beat_xfer   = y_out_valid && y_out_ready;

   // fetch starts on accept, or on the last beat of pass 0
   assign fetch_start = accept || (beat_xfer && (state == st_offd) && !pass);
   assign fetch_row   = accept ? chng.row : req.col;

   assign search_row = pass ? req.col : req.row;
   assign search_col = pass ? req.row : req.col;

   always_ff @(posedge clock)
   begin
      if (!reset)
      begin
         state <= st_idle;
         pass  <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (chng_valid)
               begin
                  state <= st_fetch;
                  pass  <= 1'b0;
               end
            end
            st_fetch:
            begin
               if (fetch_done)
               begin
                  state <= st_diag;
               end
            end
            st_diag:
            begin
               if (y_out_ready)
               begin
                  state <= st_offd;
               end
            end
            st_offd:
            begin
               if (y_out_ready)
               begin
                  if (pass)
                  begin
                     state <= st_idle;   // request complete
                  end
                  else
                  begin
                     state <= st_fetch;  // swapped pair
                     pass  <= 1'b1;
                  end
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // captured request and scan result
   always_ff @(posedge clock)
   begin
      if (accept)
      begin
         req <= chng;
      end
      if ((state == st_fetch) && fetch_done)
      begin
         res <= result;
      end
   end

   // beats built from registers, so stable while stalled
   always_comb
   begin
      y_out = '0;
      if (state == st_offd)
      begin
         y_out.yval1 = res.offdiag;
         y_out.found = res.col_found;
         y_out.last  = pass;
      end
      else
      begin
         y_out.yval1 = res.diag;
         y_out.yval2 = req.value;      // change value rides with the diagonal
         y_out.found = res.hdr_found;
      end
   end

endmodule

`default_nettype wire

//--- design/filt_y_top.sv
// ==========================================================
// Y-value filter top
// Connects the change sequencer, the row fetch unit and the
// row scanner between the change, read and output channels.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module filt_y_top (
   input  logic                        clock,
   input  logic                        reset,
   input  ymem_pkg::change_req_t       chng,
   input  logic                        chng_valid,
   output logic                        chng_ready,
   output logic [ymem_pkg::idx_w-1:0]  rd_row,
   output logic                        rd_valid,
   input  logic                        rd_ready,
   input  ymem_pkg::y_block_t          rsp_block,
   input  logic                        rsp_valid,
   output ymem_pkg::y_beat_t           y_out,
   output logic                        y_out_valid,
   input  logic                        y_out_ready
);

   import ymem_pkg::*;

   logic             fetch_start;
   logic             fetch_done;
   logic [idx_w-1:0] fetch_row;
   logic [idx_w-1:0] search_row;
   logic [idx_w-1:0] search_col;
   y_block_t         block;        // held row block
   scan_result_t     result;

   change_sequencer seq0 (
      .clock       (clock),
      .reset       (reset),
      .chng        (chng),
      .chng_valid  (chng_valid),
      .chng_ready  (chng_ready),
      .fetch_start (fetch_start),
      .fetch_row   (fetch_row),
      .search_row  (search_row),
      .search_col  (search_col),
      .fetch_done  (fetch_done),
      .result      (result),
      .y_out       (y_out),
      .y_out_valid (y_out_valid),
      .y_out_ready (y_out_ready)
   );

   row_fetch fetch0 (
      .clock       (clock),
      .reset       (reset),
      .fetch_start (fetch_start),
      .fetch_row   (fetch_row),
      .rd_row      (rd_row),
      .rd_valid    (rd_valid),
      .rd_ready    (rd_ready),
      .rsp_block   (rsp_block),
      .rsp_valid   (rsp_valid),
      .fetch_done  (fetch_done),
      .block       (block)
   );

   row_scanner scan0 (
      .block       (block),
      .search_row  (search_row),
      .search_col  (search_col),
      .result      (result)
   );

endmodule

`default_nettype wire

//--- verification/ymem_model.sv
// ==========================================================
// Y memory model
// One two-line block per row with the header at a random
// slot. Answers each read after 1 to 8 cycles and toggles
// rd_ready at random.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module ymem_model #(
   parameter int num_rows = 16
) (
   input  logic                        clock,
   input  logic                        reset,
   input  logic [ymem_pkg::idx_w-1:0]  rd_row,
   input  logic                        rd_valid,
   output logic                        rd_ready,
   output ymem_pkg::y_block_t          rsp_block,
   output logic                        rsp_valid
);

   import ymem_pkg::*;

   localparam int row_bits = $clog2(num_rows);

   y_block_t         blocks [0:num_rows-1];
   logic             ready_q = 1'b0;
   logic             valid_q = 1'b0;
   y_block_t         data_q  = '0;
   logic             took    = 1'b0;   // read accepted on the last rising edge
   logic [idx_w-1:0] row_q   = '0;
   int               left    = 0;      // cycles to the response

   assign rd_ready  = ready_q;
   assign rsp_valid = valid_q;
   assign rsp_block = data_q;

   // random column entries, then one header written over a random slot
   initial
   begin
      int hpos;
      @(posedge clock);
      for (int r = 0; r < num_rows; r++)
      begin
         for (int i = 0; i < block_entries; i++)
         begin
            blocks[r[row_bits-1:0]][i[2:0]].col.col   = idx_w'($urandom_range(0, num_rows + 3));
            blocks[r[row_bits-1:0]][i[2:0]].col.value = {part_w'($urandom), part_w'($urandom)};
         end
         hpos = $urandom_range(0, 3);
         blocks[r[row_bits-1:0]][hpos[2:0]].hdr.marker = header_marker;
         // every fifth row starting at 3 gets a header for another row
         blocks[r[row_bits-1:0]][hpos[2:0]].hdr.row = row_w'((r % 5 == 3) ? r + 256 : r);
      end
   end

   always @(posedge clock)
   begin
      took <= reset && rd_valid && ready_q;
      if (rd_valid && ready_q)
         row_q <= rd_row;
   end

   always @(negedge clock)
   begin
      if (!reset)
      begin
         ready_q <= 1'b0;
         valid_q <= 1'b0;
         left = 0;
      end
      else
      begin
         ready_q <= ($urandom_range(0, 2) != 0);
         valid_q <= 1'b0;
         if (took)
            left = $urandom_range(1, 8);
         if (left == 1)
         begin
            valid_q <= 1'b1;
            data_q  <= blocks[row_q[row_bits-1:0]];
         end
         if (left > 0)
            left = left - 1;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_filt_y.sv
// ==========================================================
// Y-value filter testbench
// Random change requests against a random Y memory. Beats
// are predicted from the header and column search rules,
// and the three handshakes are checked every cycle.
// ==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_filt_y;

   import ymem_pkg::*;

   localparam int num_rows       = 16;
   localparam int row_bits       = $clog2(num_rows);
   localparam int num_requests   = 40;
   localparam int reset_cycles   = 10;
   localparam int cycles_per_req = 60;   // two fetches, four stalled beats, overhead
   localparam int max_cycles     = reset_cycles + num_requests * cycles_per_req * 5 / 3;
   localparam logic [31:0] rng_seed = 32'hb2f3f86a;

   logic             clock       = 1'b0;
   logic             reset       = 1'b0;
   change_req_t      chng        = '0;
   logic             chng_valid  = 1'b0;
   logic             chng_ready;
   logic [idx_w-1:0] rd_row;
   logic             rd_valid;
   logic             rd_ready;
   y_block_t         rsp_block;
   logic             rsp_valid;
   y_beat_t          y_out;
   logic             y_out_valid;
   logic             y_out_ready = 1'b0;

   y_beat_t          exp_q [$];          // predicted beats in order
   string            name_q [$];
   int               cycle_count = 0;
   int               beat_count  = 0;
   logic             in_request  = 1'b0;
   logic             ready_due   = 1'b0; // chng_ready must be back this cycle
   logic             reset_q     = 1'b0;
   logic             y_hold      = 1'b0;
   logic             rd_hold     = 1'b0;
   y_beat_t          y_out_q;
   logic [idx_w-1:0] rd_row_q;

   always #2 clock = ~clock;

   filt_y_top dut0 (.*);

   ymem_model #(.num_rows(num_rows)) mem0 (.*);

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic compare_value(input string name, input y_beat_t expected,
                                input y_beat_t actual);
      assert (actual === expected)
      else
      begin
         $display("ERR %s: expected %h, actual %h", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("error: %s", what);
         abort_run();
      end
   endtask

   // header in slots 0..3, lowest slot wins; column after it, lowest slot wins
   function automatic scan_result_t predict_scan(input y_block_t blk,
                                                 input logic [idx_w-1:0] srow,
                                                 input logic [idx_w-1:0] scol);
      scan_result_t r;
      int           hpos;
      r    = '0;
      hpos = -1;
      for (int i = 3; i >= 0; i--)
         if (blk[i[2:0]].hdr.marker == 3'b111 && idx_w'(blk[i[2:0]].hdr.row) == srow)
            hpos = i;
      if (hpos >= 0)
      begin
         r.hdr_found = 1'b1;
         r.diag      = blk[hpos[2:0]].hdr.diag;
         for (int j = 7; j > hpos; j--)
         begin
            if (blk[j[2:0]].col.col == scol)
            begin
               r.col_found = 1'b1;
               r.offdiag   = blk[j[2:0]].col.value;
            end
         end
      end
      return r;
   endfunction

   task automatic queue_beats(input change_req_t req, input int id);
      scan_result_t s;
      for (int p = 0; p < 2; p++)
      begin
         if (p == 0)
            s = predict_scan(mem0.blocks[req.row[row_bits-1:0]], req.row, req.col);
         else
            s = predict_scan(mem0.blocks[req.col[row_bits-1:0]], req.col, req.row);
         exp_q.push_back('{yval1: s.diag, yval2: req.value, found: s.hdr_found, last: 1'b0});
         name_q.push_back($sformatf("req%0d pass%0d diag", id, p));
         exp_q.push_back('{yval1: s.offdiag, yval2: '0, found: s.col_found, last: (p == 1)});
         name_q.push_back($sformatf("req%0d pass%0d offdiag", id, p));
      end
   endtask

   initial
   begin
      change_req_t req;
      void'($urandom(rng_seed));
      repeat (reset_cycles) @(negedge clock);
      reset = 1'b1;
      for (int n = 0; n < num_requests; n++)
      begin
         req.row   = idx_w'($urandom_range(0, num_rows - 1));
         req.col   = idx_w'($urandom_range(0, num_rows - 1));
         req.value = {part_w'($urandom), part_w'($urandom)};
         repeat ($urandom_range(0, 3)) @(negedge clock);
         chng       = req;
         chng_valid = 1'b1;
         while (!chng_ready)
            @(negedge clock);
         queue_beats(req, n);              // accepted on the coming edge
         @(negedge clock);
         chng_valid = 1'b0;
      end
      while (exp_q.size() != 0)
         @(negedge clock);
      repeat (2) @(negedge clock);
      $display("=== PASS ===");
      $finish;
   end

   always @(negedge clock)
      y_out_ready <= reset && ($urandom_range(0, 3) != 0);

   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles)
      begin
         $display("error: timeout after %0d cycles", cycle_count);
         abort_run();
      end
   end

   // handshake and beat checks on pre-edge values
   always @(posedge clock)
   begin
      reset_q  <= reset;
      y_hold   <= reset && y_out_valid && !y_out_ready;
      rd_hold  <= reset && rd_valid && !rd_ready;
      y_out_q  <= y_out;
      rd_row_q <= rd_row;
      if (reset && !reset_q)
         require_true(!rd_valid && !y_out_valid && chng_ready, "outputs not idle after reset");
      if (reset)
      begin
         if (y_hold)
            require_true(y_out_valid && y_out == y_out_q, "y_out changed while stalled");
         if (rd_hold)
            require_true(rd_valid && rd_row == rd_row_q, "read request changed while stalled");
         if (ready_due)
            require_true(chng_ready, "chng_ready not back after the last beat");
         else if (in_request)
            require_true(!chng_ready, "chng_ready high during a request");
         ready_due <= 1'b0;
         if (chng_valid && chng_ready)
         begin
            in_request <= 1'b1;
            beat_count <= 0;
         end
         if (y_out_valid && y_out_ready)
         begin
            require_true(in_request && exp_q.size() != 0, "beat outside a request");
            compare_value(name_q.pop_front(), exp_q.pop_front(), y_out);
            beat_count <= beat_count + 1;
            if (y_out.last)
            begin
               require_true(beat_count == 3, "request did not give four beats");
               in_request <= 1'b0;
               ready_due  <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- all.f
design/ymem_pkg.sv
design/row_fetch.sv
design/row_scanner.sv
design/change_sequencer.sv
design/filt_y_top.sv
verification/ymem_model.sv
verification/tb_filt_y.sv

//--- run.sh
#!/bin/sh
# Build and run the Y-value filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_filt_y -f all.f -o sim_filt_y

./obj_dir/sim_filt_y 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation failed"
   exit 1
fi
grep -q "=== PASS ===" sim.log
